// ==== design/ldqPkg.sv ====
package ldqPkg;

  // line address without the low 8 bits of the physical address
  localparam int LINE_W = 36;
  localparam int BANK_W = 32;
  localparam int BLOW_W = 4;
  localparam int II_W = 10;

  // store check ports
  localparam int CHK_N = 2;

  typedef struct packed {
    logic [LINE_W-1:0] addrE;
    logic [LINE_W-1:0] addrO;
    // banks 0..15 low half, 16..31 high half
    logic [BANK_W-1:0] banks;
    logic [BLOW_W-1:0] bankLow;
    logic isOH;
    logic isEH;
    logic isOL;
    logic isEL;
  } ldAddrT;

  typedef struct packed {
    ldAddrT addr;
    logic [II_W-1:0] ii;
    logic thread;
  } ldNewT;

  typedef struct packed {
    ldAddrT addr;
    logic en;
  } chkT;

endpackage

// ==== design/ldqConflCmp.sv ====
`timescale 1ns/10ps

module ldqConflCmp (
  input ldqPkg::ldAddrT stored,
  input ldqPkg::ldAddrT check,
  output logic hit
);

  localparam int HALF_W = ldqPkg::BANK_W / 2;

  logic matchE;
  logic matchO;
  logic bankL;
  logic bankH;
  logic lowOvl;
  logic halfHit;

  assign matchE = stored.addrE == check.addrE;
  assign matchO = stored.addrO == check.addrO;

  assign bankL = |(stored.banks[HALF_W-1:0] & check.banks[HALF_W-1:0]);
  assign bankH = |(stored.banks[ldqPkg::BANK_W-1:HALF_W] & check.banks[ldqPkg::BANK_W-1:HALF_W]);
  assign lowOvl = |(stored.bankLow & check.bankLow);

  // any half of the stored access meeting the same half of the check
  assign halfHit = (stored.isOH & check.isOH & matchO & bankH) |
                   (stored.isOL & check.isOL & matchO & bankL) |
                   (stored.isEH & check.isEH & matchE & bankH) |
                   (stored.isEL & check.isEL & matchE & bankL);

  assign hit = halfHit & lowOvl;

endmodule

// ==== design/ldqEntry.sv ====
`timescale 1ns/10ps

module ldqEntry (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input logic aStall,
  input ldqPkg::ldNewT newLd0,
  input ldqPkg::ldNewT newLd1,
  input logic wr0,
  input logic wr1,
  input logic newConfl0,
  input logic newConfl1,
  input ldqPkg::chkT [ldqPkg::CHK_N-1:0] chkReg,
  input logic [ldqPkg::II_W-1:0] freeII0,
  input logic [ldqPkg::II_W-1:0] freeII1,
  input logic freeEn0,
  input logic freeEn1,
  input logic freeEnX0,
  input logic freeEnX1,
  output logic free,
  output logic qHit0,
  output logic qHit1
);

  ldqPkg::ldNewT ld;
  logic confl;
  logic [ldqPkg::CHK_N-1:0] cmpHit;
  logic [ldqPkg::CHK_N-1:0] chkHit;
  logic iiMatch0;
  logic iiMatch1;
  logic release0;
  logic release1;

  genvar k;
  generate
    for (k = 0; k < ldqPkg::CHK_N; k++) begin : gChk
      ldqConflCmp cmp (
        .stored(ld.addr),
        .check(chkReg[k].addr),
        .hit(cmpHit[k])
      );
      assign chkHit[k] = cmpHit[k] & chkReg[k].en & ~free;
    end
  endgenerate

  assign iiMatch0 = freeII0 == ld.ii;
  assign iiMatch1 = freeII1 == ld.ii;

  assign qHit0 = freeEn0 & ~free & iiMatch0 & confl;
  assign qHit1 = freeEn1 & ~free & iiMatch1 & confl;

  // retire only when the pipeline is not stalled
  assign release0 = freeEnX0 & iiMatch0 & ~aStall;
  assign release1 = freeEnX1 & iiMatch1 & ~aStall;

  always_ff @(posedge clk) begin
    if (rst) begin
      free <= 1'b1;
      confl <= 1'b0;
    end else if (except && exceptThread == ld.thread) begin
      free <= 1'b1;
    end else if (wr0) begin
      ld <= newLd0;
      free <= 1'b0;
      confl <= newConfl0;
    end else if (wr1) begin
      ld <= newLd1;
      free <= 1'b0;
      confl <= newConfl1;
    end else begin
      if (release0 || release1) begin
        free <= 1'b1;
      end
      // sticky until the entry is reused
      confl <= confl | (|chkHit);
    end
  end

endmodule

// ==== design/ldqAllocSel.sv ====
`timescale 1ns/10ps

module ldqAllocSel #(
  parameter int BUF_COUNT = 24
) (
  input logic [BUF_COUNT-1:0] freeMap,
  input logic newEn0,
  input logic newEn1,
  output logic [BUF_COUNT-1:0] wr0,
  output logic [BUF_COUNT-1:0] wr1
);

  logic [BUF_COUNT-1:0] lowHot;
  logic [BUF_COUNT-1:0] highHot;

  // isolate lowest set bit
  assign lowHot = freeMap & (~freeMap + 1'b1);

  always_comb begin
    highHot = '0;
    for (int i = 0; i < BUF_COUNT; i++) begin
      if (freeMap[i]) begin
        highHot = '0;
        highHot[i] = 1'b1;
      end
    end
  end

  assign wr0 = lowHot & {BUF_COUNT{newEn0}};
  assign wr1 = highHot & {BUF_COUNT{newEn1}};

endmodule

// ==== design/ldqChkStage.sv ====
`timescale 1ns/10ps

module ldqChkStage (
  input logic clk,
  input logic rst,
  input logic aStall,
  input ldqPkg::chkT [ldqPkg::CHK_N-1:0] chk,
  output ldqPkg::chkT [ldqPkg::CHK_N-1:0] chkReg
);

  // one cycle between the store ports and the compare
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < ldqPkg::CHK_N; k++) begin
        chkReg[k].en <= 1'b0;
      end
    end else if (!aStall) begin
      chkReg <= chk;
    end
  end

endmodule

// ==== design/ldqArray.sv ====
`timescale 1ns/10ps

module ldqArray #(
  parameter int BUF_COUNT = 24
) (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input logic aStall,
  input ldqPkg::ldNewT newLd0,
  input ldqPkg::ldNewT newLd1,
  input logic newEn0,
  input logic newEn1,
  input ldqPkg::chkT [ldqPkg::CHK_N-1:0] chkReg,
  input logic [ldqPkg::II_W-1:0] freeII0,
  input logic [ldqPkg::II_W-1:0] freeII1,
  input logic freeEn0,
  input logic freeEn1,
  input logic freeEnX0,
  input logic freeEnX1,
  output logic freeConfl0,
  output logic freeConfl1,
  output logic [BUF_COUNT-1:0] freeMap
);

  ldqPkg::ldNewT [1:0] newLd;
  logic [1:0][ldqPkg::CHK_N-1:0] newCmp;
  logic [1:0] newConfl;
  logic [BUF_COUNT-1:0] wr0;
  logic [BUF_COUNT-1:0] wr1;
  logic [BUF_COUNT-1:0] qHit0;
  logic [BUF_COUNT-1:0] qHit1;

  assign newLd[0] = newLd0;
  assign newLd[1] = newLd1;

  ldqAllocSel #(
    .BUF_COUNT(BUF_COUNT)
  ) allocSel (
    .freeMap(freeMap),
    .newEn0(newEn0),
    .newEn1(newEn1),
    .wr0(wr0),
    .wr1(wr1)
  );

  // incoming loads against the registered store checks
  genvar p, k;
  generate
    for (p = 0; p < 2; p++) begin : gNew
      for (k = 0; k < ldqPkg::CHK_N; k++) begin : gChk
        logic cmpHit;
        ldqConflCmp cmp (
          .stored(newLd[p].addr),
          .check(chkReg[k].addr),
          .hit(cmpHit)
        );
        assign newCmp[p][k] = cmpHit & chkReg[k].en;
      end
      assign newConfl[p] = |newCmp[p];
    end
  endgenerate

  genvar i;
  generate
    for (i = 0; i < BUF_COUNT; i++) begin : gEntry
      ldqEntry entry (
        .clk(clk),
        .rst(rst),
        .except(except),
        .exceptThread(exceptThread),
        .aStall(aStall),
        .newLd0(newLd0),
        .newLd1(newLd1),
        .wr0(wr0[i]),
        .wr1(wr1[i]),
        .newConfl0(newConfl[0]),
        .newConfl1(newConfl[1]),
        .chkReg(chkReg),
        .freeII0(freeII0),
        .freeII1(freeII1),
        .freeEn0(freeEn0),
        .freeEn1(freeEn1),
        .freeEnX0(freeEnX0),
        .freeEnX1(freeEnX1),
        .free(freeMap[i]),
        .qHit0(qHit0[i]),
        .qHit1(qHit1[i])
      );
    end
  endgenerate

  assign freeConfl0 = |qHit0;
  assign freeConfl1 = |qHit1;

endmodule

// ==== design/ldqUnit.sv ====
`timescale 1ns/10ps

module ldqUnit #(
  parameter int BUF_COUNT = 24
) (
  input logic clk,
  input logic rst,
  input logic except,
  input logic exceptThread,
  input logic aStall,
  input ldqPkg::ldNewT newLd0,
  input ldqPkg::ldNewT newLd1,
  input logic newEn0,
  input logic newEn1,
  input ldqPkg::chkT [ldqPkg::CHK_N-1:0] chk,
  input logic [ldqPkg::II_W-1:0] freeII0,
  input logic [ldqPkg::II_W-1:0] freeII1,
  input logic freeEn0,
  input logic freeEn1,
  input logic freeEnX0,
  input logic freeEnX1,
  output logic freeConfl0,
  output logic freeConfl1,
  output logic [BUF_COUNT-1:0] freeMap
);

  ldqPkg::chkT [ldqPkg::CHK_N-1:0] chkReg;

  ldqChkStage chkStage (
    .clk(clk),
    .rst(rst),
    .aStall(aStall),
    .chk(chk),
    .chkReg(chkReg)
  );

  ldqArray #(
    .BUF_COUNT(BUF_COUNT)
  ) array (
    .clk(clk),
    .rst(rst),
    .except(except),
    .exceptThread(exceptThread),
    .aStall(aStall),
    .newLd0(newLd0),
    .newLd1(newLd1),
    .newEn0(newEn0),
    .newEn1(newEn1),
    .chkReg(chkReg),
    .freeII0(freeII0),
    .freeII1(freeII1),
    .freeEn0(freeEn0),
    .freeEn1(freeEn1),
    .freeEnX0(freeEnX0),
    .freeEnX1(freeEnX1),
    .freeConfl0(freeConfl0),
    .freeConfl1(freeConfl1),
    .freeMap(freeMap)
  );

endmodule

// ==== sim/ldqModel.svh ====
`ifndef LDQ_MODEL_SVH
`define LDQ_MODEL_SVH

  // mirror of the entries and of the check register
  ldqPkg::ldNewT mLd [BUF_N];
  logic [BUF_N-1:0] mFree;
  logic [BUF_N-1:0] mConfl;
  ldqPkg::chkT mChk [ldqPkg::CHK_N];

  // conflict rule without the occupancy term
  function automatic logic ruleHit(input ldqPkg::ldAddrT ld, input ldqPkg::chkT c);
    logic lowB;
    logic highB;
    logic pair;
    lowB = (ld.banks[15:0] & c.addr.banks[15:0]) != 16'h0;
    highB = (ld.banks[31:16] & c.addr.banks[31:16]) != 16'h0;
    pair = (ld.isOH & c.addr.isOH & (ld.addrO == c.addr.addrO) & highB) |
           (ld.isOL & c.addr.isOL & (ld.addrO == c.addr.addrO) & lowB) |
           (ld.isEH & c.addr.isEH & (ld.addrE == c.addr.addrE) & highB) |
           (ld.isEL & c.addr.isEL & (ld.addrE == c.addr.addrE) & lowB);
    return c.en & pair & ((ld.bankLow & c.addr.bankLow) != 4'h0);
  endfunction

  function automatic logic modelQuery(input logic en, input logic [ldqPkg::II_W-1:0] ii);
    logic r;
    r = 1'b0;
    for (int i = 0; i < BUF_N; i++) begin
      r = r | (en && !mFree[i] && mConfl[i] && mLd[i].ii == ii);
    end
    return r;
  endfunction

  // one clock edge, using the inputs seen by the DUT at that edge
  task automatic modelStep();
    logic [BUF_N-1:0] nFree;
    logic [BUF_N-1:0] nConfl;
    logic c0;
    logic c1;
    logic hitAny;
    int lo;
    int hi;
    nFree = mFree;
    nConfl = mConfl;
    c0 = 1'b0;
    c1 = 1'b0;
    lo = -1;
    hi = -1;
    for (int k = 0; k < ldqPkg::CHK_N; k++) begin
      c0 = c0 | ruleHit(newLd0.addr, mChk[k]);
      c1 = c1 | ruleHit(newLd1.addr, mChk[k]);
    end
    for (int i = 0; i < BUF_N; i++) begin
      if (mFree[i] === 1'b1) begin
        hi = i;
        if (lo < 0) begin
          lo = i;
        end
      end
    end
    for (int i = 0; i < BUF_N; i++) begin
      hitAny = 1'b0;
      for (int k = 0; k < ldqPkg::CHK_N; k++) begin
        hitAny = hitAny | (!mFree[i] & ruleHit(mLd[i].addr, mChk[k]));
      end
      if (rst) begin
        nFree[i] = 1'b1;
        nConfl[i] = 1'b0;
      end else if (except && exceptThread == mLd[i].thread) begin
        nFree[i] = 1'b1;
      end else if (newEn0 && i == lo) begin
        mLd[i] = newLd0;
        nFree[i] = 1'b0;
        nConfl[i] = c0;
      end else if (newEn1 && i == hi) begin
        mLd[i] = newLd1;
        nFree[i] = 1'b0;
        nConfl[i] = c1;
      end else begin
        if (!aStall && ((freeEnX0 && freeII0 == mLd[i].ii) ||
                        (freeEnX1 && freeII1 == mLd[i].ii))) begin
          nFree[i] = 1'b1;
        end
        nConfl[i] = mConfl[i] | hitAny;
      end
    end
    for (int k = 0; k < ldqPkg::CHK_N; k++) begin
      if (rst) begin
        mChk[k].en = 1'b0;
      end else if (!aStall) begin
        mChk[k] = chk[k];
      end
    end
    mFree = nFree;
    mConfl = nConfl;
  endtask

`endif

// ==== sim/tbLdq.sv ====
`timescale 1ns/10ps

module tbLdq;

  localparam int BUF_N = 8;

  logic clk;
  logic rst;
  logic except;
  logic exceptThread;
  logic aStall;
  ldqPkg::ldNewT newLd0;
  ldqPkg::ldNewT newLd1;
  logic newEn0;
  logic newEn1;
  ldqPkg::chkT [ldqPkg::CHK_N-1:0] chk;
  logic [ldqPkg::II_W-1:0] freeII0;
  logic [ldqPkg::II_W-1:0] freeII1;
  logic freeEn0;
  logic freeEn1;
  logic freeEnX0;
  logic freeEnX1;
  logic freeConfl0;
  logic freeConfl1;
  logic [BUF_N-1:0] freeMap;

  logic [31:0] rngState;
  int errCount;
  int checkCount;
  int testCount;
  int testFails;
  int errAtStart;

  `include "ldqModel.svh"

  ldqUnit #(
    .BUF_COUNT(BUF_N)
  ) UUT (.*);

  always #5 clk = ~clk;

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] rnd();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // four lines in the pool, odd line next to the even one
  function automatic ldqPkg::ldAddrT makeAddr(input logic [1:0] line, input logic [31:0] banks,
                                              input logic [3:0] bankLow, input logic [3:0] flags);
    ldqPkg::ldAddrT a;
    a.addrE = {32'h8C40_1A00, 2'b00, line};
    a.addrO = {32'h8C40_1A00, 2'b01, line};
    a.banks = banks;
    a.bankLow = bankLow;
    {a.isOH, a.isEH, a.isOL, a.isEL} = flags;
    return a;
  endfunction

  function automatic ldqPkg::ldNewT makeLd(input ldqPkg::ldAddrT a, input int ii, input logic th);
    ldqPkg::ldNewT n;
    n.addr = a;
    n.ii = ii[ldqPkg::II_W-1:0];
    n.thread = th;
    return n;
  endfunction

  function ldqPkg::ldAddrT randAddr();
    logic [31:0] x;
    logic [31:0] y;
    x = rnd();
    y = rnd();
    return makeAddr(x[1:0], y & rnd(), x[5:2], x[9:6]);
  endfunction

  // model follows the edge, then all strobes drop to idle
  task automatic tick();
    @(posedge clk);
    modelStep();
    except <= 1'b0;
    aStall <= 1'b0;
    newEn0 <= 1'b0;
    newEn1 <= 1'b0;
    freeEn0 <= 1'b0;
    freeEn1 <= 1'b0;
    freeEnX0 <= 1'b0;
    freeEnX1 <= 1'b0;
    chk[0].en <= 1'b0;
    chk[1].en <= 1'b0;
  endtask

  task automatic settle();
    @(negedge clk);
    checkEq(freeMap, mFree, "freeMap");
    checkEq(freeConfl0, modelQuery(freeEn0, freeII0), "freeConfl0");
    checkEq(freeConfl1, modelQuery(freeEn1, freeII1), "freeConfl1");
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      tick();
      settle();
    end
  endtask

  task automatic alloc(input logic port, input ldqPkg::ldNewT ld);
    tick();
    if (port) begin
      newEn1 <= 1'b1;
      newLd1 <= ld;
    end else begin
      newEn0 <= 1'b1;
      newLd0 <= ld;
    end
    settle();
  endtask

  task automatic query(input logic port, input int ii, input logic exp, input string msg);
    tick();
    if (port) begin
      freeEn1 <= 1'b1;
      freeII1 <= ii[ldqPkg::II_W-1:0];
    end else begin
      freeEn0 <= 1'b1;
      freeII0 <= ii[ldqPkg::II_W-1:0];
    end
    settle();
    checkEq(port ? freeConfl1 : freeConfl0, exp, msg);
  endtask

  task automatic flush(input logic th);
    tick();
    except <= 1'b1;
    exceptThread <= th;
    settle();
    idle(1);
  endtask

  task automatic waitFree(input int idx, input logic val, input int limit);
    int n;
    n = 0;
    while (freeMap[idx] !== val) begin
      if (n == limit) begin
        $display("timeout: entry %0d never changed its free bit to %0b", idx, val);
        $display("*** TEST FAILED ***");
        $finish;
      end
      n++;
      idle(1);
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errCount != errAtStart) begin
      testFails++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
    errAtStart = errCount;
  endtask

  initial begin
    ldqPkg::ldAddrT a;
    ldqPkg::ldAddrT c;
    logic [31:0] r;
    clk = 1'b0;
    rst = 1'b1;
    except = 1'b0;
    exceptThread = 1'b0;
    aStall = 1'b0;
    newLd0 = '0;
    newLd1 = '0;
    newEn0 = 1'b0;
    newEn1 = 1'b0;
    chk = '0;
    freeII0 = '0;
    freeII1 = '0;
    freeEn0 = 1'b0;
    freeEn1 = 1'b0;
    freeEnX0 = 1'b0;
    freeEnX1 = 1'b0;
    rngState = 32'd6184;
    errCount = 0;
    checkCount = 0;
    testCount = 0;
    testFails = 0;
    errAtStart = 0;

    repeat (4) begin
      tick();
    end
    rst <= 1'b0;
    settle();
    checkEq(freeMap, {BUF_N{1'b1}}, "freeMap after reset");
    checkEq({freeConfl1, freeConfl0}, 2'b00, "freeConfl after reset");
    endTest("reset");

    // OL half only, banks in both halves
    a = makeAddr(2'd0, 32'h00F0_00F0, 4'b0011, 4'b0010);
    for (int j = 0; j < 4; j++) begin
      tick();
      newEn0 <= 1'b1;
      newLd0 <= makeLd(a, 2 * j, 1'b0);
      newEn1 <= 1'b1;
      newLd1 <= makeLd(a, 2 * j + 1, 1'b0);
      settle();
      if (j == 1) begin
        checkEq(freeMap, 8'h7E, "first pair at both ends");
      end
    end
    idle(1);
    checkEq(freeMap, 8'h00, "queue full");
    tick();
    newEn0 <= 1'b1;
    newLd0 <= makeLd(a, 60, 1'b0);
    newEn1 <= 1'b1;
    newLd1 <= makeLd(a, 61, 1'b0);
    settle();
    idle(1);
    checkEq(freeMap, 8'h00, "strobe on full queue");
    // every original load must still answer to its own II
    for (int j = 0; j < 4; j++) begin
      tick();
      freeEnX0 <= 1'b1;
      freeII0 <= 10'(2 * j);
      freeEnX1 <= 1'b1;
      freeII1 <= 10'(2 * j + 1);
      settle();
    end
    idle(1);
    checkEq(freeMap, 8'hFF, "loads kept through full-queue strobe");
    flush(1'b0);
    endTest("allocation");

    // 0 hits, then address, bank half, half flag and bankLow each differ
    for (int m = 0; m < 5; m++) begin
      c = makeAddr(m == 1 ? 2'd1 : 2'd0, m == 2 ? 32'h00F0_0000 : 32'h0000_00F0,
                   m == 4 ? 4'b1100 : 4'b0011, m == 3 ? 4'b0001 : 4'b0010);
      alloc(1'b0, makeLd(a, 20 + m, 1'b0));
      tick();
      chk[m % 2] <= '{addr: c, en: 1'b1};
      settle();
      idle(1);
      query(1'b0, 20 + m, m == 0, "store check result");
    end
    endTest("store check");

    c = makeAddr(2'd2, 32'h0003_0000, 4'b1000, 4'b1000);
    tick();
    chk[1] <= '{addr: c, en: 1'b1};
    settle();
    alloc(1'b1, makeLd(c, 30, 1'b0));
    query(1'b1, 30, 1'b1, "conflict at allocation");
    endTest("incoming load");

    flush(1'b0);
    alloc(1'b0, makeLd(a, 40, 1'b0));
    tick();
    freeEnX0 <= 1'b1;
    freeII0 <= 10'd40;
    settle();
    waitFree(0, 1'b1, 2);
    alloc(1'b0, makeLd(a, 41, 1'b0));
    tick();
    chk[0] <= '{addr: c, en: 1'b1};
    settle();
    repeat (2) begin
      tick();
      aStall <= 1'b1;
      chk[0] <= '{addr: a, en: 1'b1};
      freeEnX1 <= 1'b1;
      freeII1 <= 10'd41;
      settle();
    end
    checkEq(freeMap[0], 1'b0, "release under stall");
    query(1'b0, 41, 1'b0, "check register held under stall");
    tick();
    chk[0] <= '{addr: a, en: 1'b1};
    settle();
    idle(1);
    query(1'b0, 41, 1'b1, "check after stall");
    endTest("release");

    flush(1'b0);
    tick();
    chk[0] <= '{addr: a, en: 1'b1};
    settle();
    tick();
    newEn0 <= 1'b1;
    newLd0 <= makeLd(a, 50, 1'b0);
    newEn1 <= 1'b1;
    newLd1 <= makeLd(a, 51, 1'b1);
    settle();
    tick();
    newEn0 <= 1'b1;
    newLd0 <= makeLd(c, 52, 1'b0);
    newEn1 <= 1'b1;
    newLd1 <= makeLd(c, 53, 1'b1);
    settle();
    flush(1'b1);
    tick();
    freeEn0 <= 1'b1;
    freeII0 <= 10'd50;
    freeEn1 <= 1'b1;
    freeII1 <= 10'd51;
    settle();
    checkEq(freeMap, 8'hFC, "thread 1 entries released");
    checkEq(freeConfl0, 1'b1, "thread 0 flag kept");
    checkEq(freeConfl1, 1'b0, "thread 1 load gone");
    endTest("exception");

    flush(1'b0);
    for (int n = 0; n < 400; n++) begin
      tick();
      r = rnd();
      // no allocation in an exception cycle
      if (r[3:0] == 4'h0) begin
        except <= 1'b1;
        exceptThread <= r[4];
      end else begin
        newEn0 <= r[5] & r[6];
        newEn1 <= r[7] & r[8];
      end
      aStall <= r[11:9] == 3'b000;
      newLd0 <= makeLd(randAddr(), {28'h0, r[19:16]}, r[28]);
      newLd1 <= makeLd(randAddr(), {28'h0, r[23:20]}, r[29]);
      chk[0] <= '{addr: randAddr(), en: r[12]};
      chk[1] <= '{addr: randAddr(), en: r[13]};
      freeEn0 <= r[14];
      freeII0 <= {6'h0, r[19:16]};
      freeEn1 <= r[15];
      freeII1 <= {6'h0, r[23:20]};
      freeEnX0 <= r[24] & r[25];
      freeEnX1 <= r[26] & r[27];
      settle();
    end
    endTest("random");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, testFails, checkCount, errCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+sim
design/ldqPkg.sv
design/ldqConflCmp.sv
design/ldqEntry.sv
design/ldqAllocSel.sv
design/ldqChkStage.sv
design/ldqArray.sv
design/ldqUnit.sv
sim/tbLdq.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module tbLdq -o simLdq
./obj_dir/simLdq | tee sim.log
if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
